/* common/isa_pkg.sv */
/* RV32I subset definitions for the instruction engine
   Major opcodes, function fields, ALU operations and the decoded instruction */
package isa_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Major opcodes kept from the base ISA
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111
  } opcode_e;

  // funct3 codes shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 for register-register forms
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // One instruction after decode
  typedef struct packed {
    alu_op_e                alu_op;
    logic                   use_imm;
    logic                   is_jal;
    logic                   rd_we;
    logic                   illegal;
    logic [REG_ADDR_W-1:0]  rs1;
    logic [REG_ADDR_W-1:0]  rs2;
    logic [REG_ADDR_W-1:0]  rd;
    logic [XLEN-1:0]        imm;
  } decoded_t;

endpackage

/* common/pipe_pkg.sv */
/* Pipeline records of the instruction engine
   Fetch bus, buffer entry, redirect and retire trace */
package pipe_pkg;

  // Free-entry count width, covers buffers of up to 8 entries
  localparam int unsigned FREE_W = 4;

  typedef struct packed {
    logic                       req;
    logic [isa_pkg::XLEN-1:0]   addr;
  } fetch_req_t;

  typedef struct packed {
    logic                       gnt;
    logic                       rvalid;
    logic [isa_pkg::XLEN-1:0]   rdata;
  } fetch_rsp_t;

  // What the prefetch buffer stores
  typedef struct packed {
    logic [isa_pkg::XLEN-1:0]   pc;
    logic [isa_pkg::XLEN-1:0]   insn;
  } fetch_entry_t;

  typedef struct packed {
    logic                       valid;
    logic [isa_pkg::XLEN-1:0]   target;
  } redirect_t;

  typedef struct packed {
    logic                           valid;
    logic [isa_pkg::XLEN-1:0]       pc;
    logic [isa_pkg::XLEN-1:0]       insn;
    logic [isa_pkg::REG_ADDR_W-1:0] rd;
    logic [isa_pkg::XLEN-1:0]       rd_wdata;
    logic                           illegal;
  } retire_t;

endpackage

/* dv/tb_iss_model.svh */
/* Reference model for the instruction engine testbench
   xorshift source, random program generator and RV32I subset model */
`ifndef TB_ISS_MODEL_SVH
`define TB_ISS_MODEL_SVH

logic [31:0] rng_state;
logic [31:0] prog_mem [64];
logic [31:0] model_rf [32];
logic [31:0] model_pc;

function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// One word from the subset, or a raw random word about one time in ten
function automatic logic [31:0] random_insn();
  logic [31:0] r;
  logic [31:0] imm;
  logic [31:0] word;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [20:0] off;
  int          words;
  r     = next_random();
  imm   = next_random();
  rd    = {2'b00, r[10:8]};
  rs1   = {2'b00, r[13:11]};
  rs2   = {2'b00, r[16:14]};
  words = int'(r[21:17]) - 16;
  if (words == 0) begin
    words = 16;
  end
  off = 21'(words * 4);
  case ((r >> 22) % 20)
    0, 1:    word = next_random();
    2, 3:    word = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    4:       word = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    5:       word = {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
    6:       word = {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
    7:       word = {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
    8:       word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    9:       word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
    10:      word = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
    11:      word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
    12:      word = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
    13:      word = {imm[31:12], rd, 7'b0110111};
    default: word = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
  endcase
  return word;
endfunction

task automatic reset_model(input logic [31:0] seed, input logic [31:0] boot);
  rng_state = seed;
  for (int i = 0; i < 64; i++) begin
    prog_mem[i] = random_insn();
  end
  for (int i = 0; i < 32; i++) begin
    model_rf[i] = '0;
  end
  model_pc = boot;
endtask

// Retires one word at model_pc and returns what the trace should show
task automatic step_model(input logic [31:0] insn, output logic illegal,
                          output logic [4:0] rd, output logic [31:0] wdata);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] val;
  logic [31:0] next_pc;
  a       = model_rf[insn[19:15]];
  b       = model_rf[insn[24:20]];
  imm_i   = {{20{insn[31]}}, insn[31:20]};
  illegal = 1'b0;
  val     = '0;
  next_pc = model_pc + 32'd4;
  // Key is funct7, funct3, opcode
  casez ({insn[31:25], insn[14:12], insn[6:0]})
    17'b???????_000_0010011: val = a + imm_i;
    17'b???????_100_0010011: val = a ^ imm_i;
    17'b???????_110_0010011: val = a | imm_i;
    17'b???????_111_0010011: val = a & imm_i;
    17'b0000000_000_0110011: val = a + b;
    17'b0100000_000_0110011: val = a - b;
    17'b0000000_100_0110011: val = a ^ b;
    17'b0000000_110_0110011: val = a | b;
    17'b0000000_111_0110011: val = a & b;
    17'b???????_???_0110111: val = {insn[31:12], 12'b0};
    17'b???????_???_1101111: begin
      val     = model_pc + 32'd4;
      next_pc = model_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    end
    default: illegal = 1'b1;
  endcase
  rd = insn[11:7];
  if (illegal || rd == 5'd0) begin
    rd    = 5'd0;
    wdata = '0;
  end else begin
    model_rf[rd] = val;
    wdata        = val;
  end
  model_pc = next_pc;
endtask

`endif

/* dv/tb_mini_core.sv */
/* Testbench for the RV32I subset instruction engine
   Random program and fetch bus timing, retire trace checked against a model */
`timescale 1ns/1ps

module tb_mini_core;

  import pipe_pkg::*;

  localparam logic [31:0] BootAddr        = 32'h0000_0080;
  localparam int          FifoDepth       = 4;
  localparam int          NumRetire       = 400;
  // Generous cost of one retirement, stalls and discarded fetches included
  localparam int          CyclesPerRetire = 12;
  localparam int          TimeoutCycles   = NumRetire * CyclesPerRetire + 200;

  logic        clk;
  logic        rst_ni;
  fetch_req_t  instr_req;
  fetch_rsp_t  instr_rsp;
  retire_t     retire;
  logic        pend;
  logic [31:0] pend_addr;
  int          rv_wait;
  int          gnt_wait;
  logic        seen_req;
  logic [31:0] seen_addr;
  int          cycles;
  int          retired;

  `include "tb_iss_model.svh"

  mini_core #(
    .BootAddr  ( BootAddr  ),
    .FifoDepth ( FifoDepth )
  ) UUT (
    .clk         ( clk       ),
    .rst_ni      ( rst_ni    ),
    .instr_req_o ( instr_req ),
    .instr_rsp_i ( instr_rsp ),
    .retire_o    ( retire    )
  );

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got %h expected %h", name, got, exp);
    stop_on_error();
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_on_error();
  endtask

  // Mostly 0 to 3 cycles, now and then a long stall
  function automatic int grant_delay();
    logic [31:0] r;
    r = next_random();
    if (r[7:3] == 5'd0) begin
      return 12 + int'(r[11:8]);
    end
    return int'(r[1:0]);
  endfunction

  initial begin
    clk       = 1'b0;
    rst_ni    = 1'b0;
    instr_rsp = '0;
    pend      = 1'b0;
    pend_addr = '0;
    rv_wait   = 0;
    gnt_wait  = -1;
    seen_req  = 1'b0;
    seen_addr = '0;
    cycles    = 0;
    retired   = 0;
    reset_model(32'hb853, BootAddr);
    repeat (2) @(posedge clk);
    #1 rst_ni = 1'b1;
  end

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////////
  // Instruction memory responder
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    #1;
    if (rst_ni) begin
      // Grant taken at the last edge
      if (seen_req && instr_rsp.gnt) begin
        pend      = 1'b1;
        pend_addr = seen_addr;
        rv_wait   = int'(next_random() % 3);
        gnt_wait  = -1;
      end
      if (seen_req && !instr_rsp.gnt) begin
        assert (instr_req.req)
          else report_failure("fetch request dropped before it was granted");
        assert (instr_req.addr == seen_addr)
          else report_mismatch("instr_req_o.addr", instr_req.addr, seen_addr);
      end
      assert (!(instr_req.req && pend))
        else report_failure("fetch request raised while a response was outstanding");
      instr_rsp = '0;
      if (pend) begin
        if (rv_wait == 0) begin
          instr_rsp.rvalid = 1'b1;
          instr_rsp.rdata  = prog_mem[pend_addr[7:2]];
          pend             = 1'b0;
        end else begin
          rv_wait--;
        end
      end
      seen_req  = instr_req.req;
      seen_addr = instr_req.addr;
      if (seen_req) begin
        if (gnt_wait < 0) begin
          gnt_wait = grant_delay();
        end
        if (gnt_wait == 0) begin
          instr_rsp.gnt = 1'b1;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Retire checks and run control
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : check_retire
    logic [31:0] exp_pc;
    logic [31:0] exp_insn;
    logic        exp_illegal;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata;
    #1;
    if (rst_ni && retire.valid) begin
      exp_pc   = model_pc;
      exp_insn = prog_mem[model_pc[7:2]];
      step_model(exp_insn, exp_illegal, exp_rd, exp_wdata);
      assert (retire.pc == exp_pc)
        else report_mismatch("retire_o.pc", retire.pc, exp_pc);
      assert (retire.insn == exp_insn)
        else report_mismatch("retire_o.insn", retire.insn, exp_insn);
      assert (retire.illegal == exp_illegal)
        else report_mismatch("retire_o.illegal", 32'(retire.illegal), 32'(exp_illegal));
      assert (retire.rd == exp_rd)
        else report_mismatch("retire_o.rd", 32'(retire.rd), 32'(exp_rd));
      assert (retire.rd_wdata == exp_wdata)
        else report_mismatch("retire_o.rd_wdata", retire.rd_wdata, exp_wdata);
      retired++;
      if (retired == NumRetire) begin
        $display("sim passed");
        $finish;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    assert (cycles < TimeoutCycles)
      else report_failure($sformatf("timeout after %0d cycles, %0d of %0d instructions retired",
                                    cycles, retired, NumRetire));
  end

endmodule

/* exec/exec_decoder.sv */
/* Instruction decoder for the RV32I subset
   Maps a word to ALU operation, register fields, immediate and illegal flag */
`timescale 1ns/1ps

module exec_decoder (
  input  logic [isa_pkg::XLEN-1:0]  insn_i,
  output isa_pkg::decoded_t         dec_o
);

  import isa_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(insn_i[6:0]);
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  // Immediate formats
  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_u = {insn_i[31:12], 12'b0};
  assign imm_j = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};

  always_comb begin
    dec_o        = '0;
    dec_o.alu_op = ALU_PASS_B;
    dec_o.rs1    = insn_i[19:15];
    dec_o.rs2    = insn_i[24:20];
    dec_o.rd     = insn_i[11:7];

    case (opcode)
      OP_IMM: begin
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_i;
        dec_o.rd_we   = 1'b1;
        case (funct3)
          F3_ADD:  dec_o.alu_op = ALU_ADD;
          F3_XOR:  dec_o.alu_op = ALU_XOR;
          F3_OR:   dec_o.alu_op = ALU_OR;
          F3_AND:  dec_o.alu_op = ALU_AND;
          default: dec_o.illegal = 1'b1;
        endcase
      end
      OP: begin
        dec_o.rd_we = 1'b1;
        if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD:  dec_o.alu_op = ALU_ADD;
            F3_XOR:  dec_o.alu_op = ALU_XOR;
            F3_OR:   dec_o.alu_op = ALU_OR;
            F3_AND:  dec_o.alu_op = ALU_AND;
            default: dec_o.illegal = 1'b1;
          endcase
        end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
          dec_o.alu_op = ALU_SUB;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end
      LUI: begin
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_u;
        dec_o.rd_we   = 1'b1;
      end
      JAL: begin
        dec_o.is_jal = 1'b1;
        dec_o.imm    = imm_j;
        dec_o.rd_we  = 1'b1;
      end
      default: dec_o.illegal = 1'b1;
    endcase

    // Anything outside the subset writes nothing and does not jump
    if (dec_o.illegal) begin
      dec_o.rd_we  = 1'b0;
      dec_o.is_jal = 1'b0;
    end
  end

endmodule

/* exec/exec_stage.sv */
/* Execute stage
   Register file, ALU, JAL redirect and the registered retire record */
`timescale 1ns/1ps

module exec_stage (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    head_valid_i,
  input  pipe_pkg::fetch_entry_t  head_i,
  output logic                    pop_o,
  output pipe_pkg::redirect_t     redirect_o,
  output pipe_pkg::retire_t       retire_o
);

  import isa_pkg::*;
  import pipe_pkg::*;

  decoded_t        dec;
  logic [XLEN-1:0] rf_q [1:31];
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] link_addr;
  logic [XLEN-1:0] wdata;
  logic            rf_we;
  retire_t         retire_q;

  exec_decoder u_decoder (
    .insn_i ( head_i.insn ),
    .dec_o  ( dec         )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operands and ALU
  ////////////////////////////////////////////////////////////////////////////

  // x0 has no storage
  assign rs1_data = (dec.rs1 == '0) ? '0 : rf_q[dec.rs1];
  assign rs2_data = (dec.rs2 == '0) ? '0 : rf_q[dec.rs2];
  assign op_b     = dec.use_imm ? dec.imm : rs2_data;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_res = rs1_data + op_b;
      ALU_SUB:    alu_res = rs1_data - op_b;
      ALU_XOR:    alu_res = rs1_data ^ op_b;
      ALU_OR:     alu_res = rs1_data | op_b;
      ALU_AND:    alu_res = rs1_data & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  assign link_addr = head_i.pc + XLEN'(4);
  assign wdata     = dec.is_jal ? link_addr : alu_res;

  // Always ready so every head entry retires in the cycle it shows up
  assign pop_o = head_valid_i;
  assign rf_we = head_valid_i && dec.rd_we && (dec.rd != '0);

  assign redirect_o.valid  = head_valid_i && dec.is_jal;
  assign redirect_o.target = head_i.pc + dec.imm;

  ////////////////////////////////////////////////////////////////////////////
  // Register file and retire
  ////////////////////////////////////////////////////////////////////////////

  // Registers x1 to x31 clear on reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rf_we) begin
      rf_q[dec.rd] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_q <= '0;
    end else begin
      retire_q.valid <= head_valid_i;
      if (head_valid_i) begin
        retire_q.pc       <= head_i.pc;
        retire_q.insn     <= head_i.insn;
        retire_q.rd       <= rf_we ? dec.rd : '0;
        retire_q.rd_wdata <= rf_we ? wdata : '0;
        retire_q.illegal  <= dec.illegal;
      end
    end
  end

  assign retire_o = retire_q;

  a_x0_quiet: assert property (@(posedge clk) disable iff (!rst_ni)
    retire_o.valid && (retire_o.rd == '0) |-> retire_o.rd_wdata == '0);

endmodule

/* mini_core.f */
+incdir+dv
common/isa_pkg.sv
common/pipe_pkg.sv
verilog/fetch_unit.sv
verilog/prefetch_fifo.sv
exec/exec_decoder.sv
exec/exec_stage.sv
verilog/mini_core.sv
dv/tb_mini_core.sv

/* verilog/fetch_unit.sv */
/* Instruction fetch unit
   Runs the fetch PC over the req/gnt/rvalid bus and feeds the prefetch buffer */
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [isa_pkg::XLEN-1:0] BootAddr = 32'h0000_0080
) (
  input  logic                          clk,
  input  logic                          rst_ni,
  output pipe_pkg::fetch_req_t          bus_req_o,
  input  pipe_pkg::fetch_rsp_t          bus_rsp_i,
  input  logic [pipe_pkg::FREE_W-1:0]   free_i,
  input  pipe_pkg::redirect_t           redirect_i,
  output logic                          push_o,
  output pipe_pkg::fetch_entry_t        push_entry_o
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0] pc_q, pc_d;
  logic [XLEN-1:0] req_addr_q;
  logic [XLEN-1:0] fetch_addr;
  logic            fetch_en_q;
  logic            out_q, out_d;
  logic            hold_q, hold_d;
  logic            discard_q, discard_d;
  logic            req_ok;
  logic            granted;
  logic            resp_done;

  // One word in flight at most, so a single free slot is enough
  assign req_ok    = fetch_en_q && !out_q && (free_i != '0);
  assign granted   = req_ok && bus_rsp_i.gnt;
  assign resp_done = out_q && bus_rsp_i.rvalid;

  // A request left waiting for gnt keeps its address even across a redirect
  assign fetch_addr      = hold_q ? req_addr_q : pc_q;
  assign bus_req_o.req   = req_ok;
  assign bus_req_o.addr  = fetch_addr;

  // Stale responses are dropped here, the buffer never sees them
  assign push_o            = resp_done && !discard_q && !redirect_i.valid;
  assign push_entry_o.pc   = req_addr_q;
  assign push_entry_o.insn = bus_rsp_i.rdata;

  always_comb begin
    pc_d      = pc_q;
    out_d     = out_q;
    hold_d    = hold_q;
    discard_d = discard_q;
    if (resp_done) begin
      out_d     = 1'b0;
      discard_d = 1'b0;
    end
    if (granted) begin
      out_d  = 1'b1;
      hold_d = 1'b0;
      // PC already holds the redirect target when the request went stale
      if (!discard_q) begin
        pc_d = pc_q + XLEN'(4);
      end
    end else if (req_ok) begin
      hold_d = 1'b1;
    end
    if (redirect_i.valid) begin
      pc_d = redirect_i.target;
      if (req_ok || (out_q && !bus_rsp_i.rvalid)) begin
        discard_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q <= 1'b0;
      pc_q       <= BootAddr;
      out_q      <= 1'b0;
      hold_q     <= 1'b0;
      discard_q  <= 1'b0;
    end else begin
      fetch_en_q <= 1'b1;
      pc_q       <= pc_d;
      out_q      <= out_d;
      hold_q     <= hold_d;
      discard_q  <= discard_d;
    end
  end

  // Address of the request on the bus, later the PC of its response
  always_ff @(posedge clk) begin
    if (req_ok) begin
      req_addr_q <= fetch_addr;
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (!rst_ni)
    bus_req_o.req && !bus_rsp_i.gnt |=> bus_req_o.req && $stable(bus_req_o.addr));

endmodule

/* verilog/mini_core.sv */
/* In-order RV32I subset instruction engine
   Fetch unit, prefetch buffer and execute stage with a retire trace */
`timescale 1ns/1ps

module mini_core #(
  parameter logic [isa_pkg::XLEN-1:0] BootAddr  = 32'h0000_0080,
  parameter int unsigned              FifoDepth = 4
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  output pipe_pkg::fetch_req_t  instr_req_o,
  input  pipe_pkg::fetch_rsp_t  instr_rsp_i,
  output pipe_pkg::retire_t     retire_o
);

  import pipe_pkg::*;

  logic              push;
  fetch_entry_t      push_entry;
  logic [FREE_W-1:0] free;
  logic              head_valid;
  fetch_entry_t      head;
  logic              pop;
  redirect_t         redirect;

  fetch_unit #(
    .BootAddr ( BootAddr )
  ) u_fetch (
    .clk          ( clk         ),
    .rst_ni       ( rst_ni      ),
    .bus_req_o    ( instr_req_o ),
    .bus_rsp_i    ( instr_rsp_i ),
    .free_i       ( free        ),
    .redirect_i   ( redirect    ),
    .push_o       ( push        ),
    .push_entry_o ( push_entry  )
  );

  // A taken JAL empties the buffer at the same edge
  prefetch_fifo #(
    .FifoDepth ( FifoDepth )
  ) u_fifo (
    .clk          ( clk            ),
    .rst_ni       ( rst_ni         ),
    .push_i       ( push           ),
    .push_entry_i ( push_entry     ),
    .flush_i      ( redirect.valid ),
    .free_o       ( free           ),
    .head_valid_o ( head_valid     ),
    .head_o       ( head           ),
    .pop_i        ( pop            )
  );

  exec_stage u_exec (
    .clk          ( clk        ),
    .rst_ni       ( rst_ni     ),
    .head_valid_i ( head_valid ),
    .head_i       ( head       ),
    .pop_o        ( pop        ),
    .redirect_o   ( redirect   ),
    .retire_o     ( retire_o   )
  );

endmodule

/* verilog/prefetch_fifo.sv */
/* Prefetch buffer between fetch and execute
   Circular FIFO of fetched words with flush and free-entry count */
`timescale 1ns/1ps

module prefetch_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                          clk,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  pipe_pkg::fetch_entry_t        push_entry_i,
  input  logic                          flush_i,
  output logic [pipe_pkg::FREE_W-1:0]   free_o,
  output logic                          head_valid_o,
  output pipe_pkg::fetch_entry_t        head_o,
  input  logic                          pop_i
);

  import pipe_pkg::*;

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  fetch_entry_t      mem_q [FifoDepth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [FREE_W-1:0] count_q;
  logic              do_push;
  logic              do_pop;

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign free_o       = FREE_W'(FifoDepth) - count_q;

  // Flush wins over both sides
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + PtrW'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PtrW'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + FREE_W'(1);
        2'b01:   count_q <= count_q - FREE_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  // Fetch must only ask for words it has room for
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_ni)
    push_i |-> count_q < FREE_W'(FifoDepth));

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_ni)
    pop_i |-> head_valid_o);

endmodule
